// ==== pkt_pkg.sv ====
package pkt_pkg;

    //==============================
    // Data path sizes
    //==============================
    // Bytes carried by one data beat
    localparam int DATA_BYTE_WID = 8;
    localparam int DATA_WID = DATA_BYTE_WID * 8;
    // Byte lane select bits within a beat
    localparam int BYTE_SEL_WID = $clog2(DATA_BYTE_WID);

    // Packet metadata and byte length
    localparam int META_WID = 6;
    localparam int LEN_WID = 10;
    // Beat count of the longest encodable length, rounded up
    localparam int BEAT_WID = LEN_WID + 1 - BYTE_SEL_WID;

    //==============================
    // Memory and buffer sizes
    //==============================
    localparam int PLAY_DEPTH = 64;
    localparam int CAP_DEPTH = 128;
    localparam int ADDR_WID = $clog2(PLAY_DEPTH);
    localparam int CAP_ADDR_WID = $clog2(CAP_DEPTH);

    // Packet FIFO, also the playback credit pool
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_WID = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WID = $clog2(FIFO_DEPTH + 1);

    // Capture input stage, also the FIFO-to-capture credit pool
    localparam int CAP_IN_DEPTH = 2;
    localparam int CAP_IN_PTR_WID = $clog2(CAP_IN_DEPTH);
    localparam int CAP_CRED_WID = $clog2(CAP_IN_DEPTH + 1);

    //==============================
    // Header layout
    //==============================
    // Len in the low bits, meta above it
    typedef struct packed {
        logic [DATA_WID-META_WID-LEN_WID-1:0] pad;
        logic [META_WID-1:0]                  meta;
        logic [LEN_WID-1:0]                   len;
    } pkt_hdr_t;

    // One FIFO word, seen as header or as raw beat
    // The is_hdr bit travelling alongside picks the view
    typedef union packed {
        pkt_hdr_t            hdr;
        logic [DATA_WID-1:0] data;
    } fifo_word_u;

    // Number of data beats for a byte length, ceil(len / DATA_BYTE_WID)
    function automatic logic [BEAT_WID-1:0] beat_count(input logic [LEN_WID-1:0] len);
        logic [LEN_WID:0] rounded;
        rounded = {1'b0, len} + (LEN_WID + 1)'(DATA_BYTE_WID - 1);
        return rounded[LEN_WID:BYTE_SEL_WID];
    endfunction

endpackage

// ==== packet_playback.sv ====
module packet_playback (
    input  logic                               clk,
    input  logic                               rst_n,
    // Playback memory load
    input  logic                               play_wr_en,
    input  logic [pkt_pkg::ADDR_WID-1:0]       play_wr_addr,
    input  logic [pkt_pkg::DATA_WID-1:0]       play_wr_data,
    // Start command
    input  logic                               start,
    input  logic [pkt_pkg::ADDR_WID-1:0]       start_addr,
    input  logic [pkt_pkg::LEN_WID-1:0]        start_len,
    input  logic [pkt_pkg::META_WID-1:0]       start_meta,
    output logic                               busy,
    // Credit link towards the FIFO
    input  logic                               pb_credit,
    output logic                               pb_valid,
    output logic                               pb_is_hdr,
    output pkt_pkg::fifo_word_u                pb_word
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_DATA
    } state_t;

    state_t                            state;
    logic [pkt_pkg::DATA_WID-1:0]      play_mem [pkt_pkg::PLAY_DEPTH];
    logic [pkt_pkg::ADDR_WID-1:0]      rd_addr;
    logic [pkt_pkg::LEN_WID-1:0]       pkt_len;
    logic [pkt_pkg::META_WID-1:0]      pkt_meta;
    logic [pkt_pkg::BEAT_WID-1:0]      beats_left;
    logic [pkt_pkg::FIFO_CNT_WID-1:0]  credit;

    //==============================
    // Playback memory
    //==============================
    // Written by the load port only
    always_ff @(posedge clk)
    begin
        if (play_wr_en)
        begin
            play_mem[play_wr_addr] <= play_wr_data;
        end
    end

    //==============================
    // Word generation
    //==============================
    assign busy = (state != ST_IDLE);
    // Any busy cycle with credit in hand sends one word
    assign pb_valid = busy && (credit != '0);
    assign pb_is_hdr = (state == ST_HDR);

    always_comb
    begin
        // Pad bits of the header stay zero
        pb_word = '0;
        if (state == ST_HDR)
        begin
            pb_word.hdr.meta = pkt_meta;
            pb_word.hdr.len = pkt_len;
        end
        else
        begin
            pb_word.data = play_mem[rd_addr];
        end
    end

    // Credit pool, starts full
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            credit <= pkt_pkg::FIFO_CNT_WID'(pkt_pkg::FIFO_DEPTH);
        else
            credit <= credit + pkt_pkg::FIFO_CNT_WID'(pb_credit)
                      - pkt_pkg::FIFO_CNT_WID'(pb_valid);
    end

    // Header fields held for the whole packet
    always_ff @(posedge clk)
    begin
        if (start && !busy)
        begin
            pkt_len <= start_len;
            pkt_meta <= start_meta;
        end
    end

    // Packet FSM
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
            rd_addr <= '0;
            beats_left <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state <= ST_HDR;
                        rd_addr <= start_addr;
                        beats_left <= pkt_pkg::beat_count(start_len);
                    end
                end
                ST_HDR:
                begin
                    // Zero length packet ends with its header
                    if (pb_valid)
                        state <= (beats_left == '0) ? ST_IDLE : ST_DATA;
                end
                ST_DATA:
                begin
                    if (pb_valid)
                    begin
                        // Address wraps around the memory
                        rd_addr <= rd_addr + 1'b1;
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == pkt_pkg::BEAT_WID'(1))
                            state <= ST_IDLE;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== packet_fifo.sv ====
module packet_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    // From playback
    input  logic                 pb_valid,
    input  logic                 pb_is_hdr,
    input  pkt_pkg::fifo_word_u  pb_word,
    output logic                 pb_credit,
    // To capture
    input  logic                 cap_credit,
    output logic                 cap_valid,
    output logic                 cap_is_hdr,
    output pkt_pkg::fifo_word_u  cap_word
);

    pkt_pkg::fifo_word_u               word_mem [pkt_pkg::FIFO_DEPTH];
    logic                              hdr_mem [pkt_pkg::FIFO_DEPTH];
    logic [pkt_pkg::FIFO_PTR_WID-1:0]  wr_ptr;
    logic [pkt_pkg::FIFO_PTR_WID-1:0]  rd_ptr;
    logic [pkt_pkg::FIFO_CNT_WID-1:0]  count;
    logic [pkt_pkg::CAP_CRED_WID-1:0]  credit;

    //==============================
    // Storage
    //==============================
    // Playback credits guarantee a free entry
    always_ff @(posedge clk)
    begin
        if (pb_valid)
        begin
            word_mem[wr_ptr] <= pb_word;
            hdr_mem[wr_ptr] <= pb_is_hdr;
        end
    end

    // Head entry, shown as soon as it is written
    assign cap_word = word_mem[rd_ptr];
    assign cap_is_hdr = hdr_mem[rd_ptr];

    //==============================
    // Send and credit return
    //==============================
    // One word per cycle while capture has room
    assign cap_valid = (count != '0) && (credit != '0);
    // Sending the head frees its entry
    assign pb_credit = cap_valid;

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (pb_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (cap_valid)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + pkt_pkg::FIFO_CNT_WID'(pb_valid)
                     - pkt_pkg::FIFO_CNT_WID'(cap_valid);
        end
    end

    // Capture link credits, one per input stage entry
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            credit <= pkt_pkg::CAP_CRED_WID'(pkt_pkg::CAP_IN_DEPTH);
        else
            credit <= credit + pkt_pkg::CAP_CRED_WID'(cap_credit)
                      - pkt_pkg::CAP_CRED_WID'(cap_valid);
    end

endmodule

// ==== packet_capture.sv ====
module packet_capture (
    input  logic                               clk,
    input  logic                               rst_n,
    // From the FIFO
    input  logic                               cap_valid,
    input  logic                               cap_is_hdr,
    input  pkt_pkg::fifo_word_u                cap_word,
    output logic                               cap_credit,
    // Monitor enable
    input  logic                               cap_en,
    // Descriptor of a finished packet
    output logic                               desc_valid,
    output logic [pkt_pkg::LEN_WID-1:0]        desc_len,
    output logic [pkt_pkg::META_WID-1:0]       desc_meta,
    output logic [pkt_pkg::CAP_ADDR_WID-1:0]   desc_addr,
    // Capture memory read back
    input  logic [pkt_pkg::CAP_ADDR_WID-1:0]   cap_rd_addr,
    output logic [pkt_pkg::DATA_WID-1:0]       cap_rd_data
);

    pkt_pkg::fifo_word_u                 in_mem [pkt_pkg::CAP_IN_DEPTH];
    logic                                in_hdr [pkt_pkg::CAP_IN_DEPTH];
    logic [pkt_pkg::CAP_IN_PTR_WID-1:0]  in_wr;
    logic [pkt_pkg::CAP_IN_PTR_WID-1:0]  in_rd;
    logic [pkt_pkg::CAP_CRED_WID-1:0]    in_cnt;
    logic                                pop;
    pkt_pkg::fifo_word_u                 head;
    logic [pkt_pkg::BEAT_WID-1:0]        hdr_beats;
    logic [pkt_pkg::BEAT_WID-1:0]        beats_left;
    logic [pkt_pkg::CAP_ADDR_WID-1:0]    wr_ptr;
    logic [pkt_pkg::DATA_WID-1:0]        cap_mem [pkt_pkg::CAP_DEPTH];

    //==============================
    // Input stage
    //==============================
    always_ff @(posedge clk)
    begin
        if (cap_valid)
        begin
            in_mem[in_wr] <= cap_word;
            in_hdr[in_wr] <= cap_is_hdr;
        end
    end

    // Retire one entry per cycle while enabled
    assign pop = cap_en && (in_cnt != '0);
    assign cap_credit = pop;
    assign head = in_mem[in_rd];
    assign hdr_beats = pkt_pkg::beat_count(head.hdr.len);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_wr <= '0;
            in_rd <= '0;
            in_cnt <= '0;
        end
        else
        begin
            if (cap_valid)
                in_wr <= in_wr + 1'b1;
            if (pop)
                in_rd <= in_rd + 1'b1;
            in_cnt <= in_cnt + pkt_pkg::CAP_CRED_WID'(cap_valid)
                      - pkt_pkg::CAP_CRED_WID'(pop);
        end
    end

    //==============================
    // Header decode and beat count
    //==============================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beats_left <= '0;
            wr_ptr <= '0;
            desc_valid <= 1'b0;
        end
        else
        begin
            desc_valid <= 1'b0;
            if (pop && in_hdr[in_rd])
            begin
                beats_left <= hdr_beats;
                // Empty packet is reported straight away
                if (hdr_beats == '0)
                    desc_valid <= 1'b1;
            end
            else if (pop)
            begin
                // Circular write pointer
                wr_ptr <= wr_ptr + 1'b1;
                beats_left <= beats_left - 1'b1;
                if (beats_left == pkt_pkg::BEAT_WID'(1))
                    desc_valid <= 1'b1;
            end
        end
    end

    // Descriptor fields, taken from the header
    always_ff @(posedge clk)
    begin
        if (pop && in_hdr[in_rd])
        begin
            desc_len <= head.hdr.len;
            desc_meta <= head.hdr.meta;
            // Packet starts where the last one ended
            desc_addr <= wr_ptr;
        end
    end

    //==============================
    // Capture memory
    //==============================
    always_ff @(posedge clk)
    begin
        if (pop && !in_hdr[in_rd])
            cap_mem[wr_ptr] <= head.data;
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk)
    begin
        cap_rd_data <= cap_mem[cap_rd_addr];
    end

endmodule

// ==== packet_loopback_top.sv ====
module packet_loopback_top (
    input  logic                               clk,
    input  logic                               rst_n,
    // Playback memory load
    input  logic                               play_wr_en,
    input  logic [pkt_pkg::ADDR_WID-1:0]       play_wr_addr,
    input  logic [pkt_pkg::DATA_WID-1:0]       play_wr_data,
    // Start command
    input  logic                               start,
    input  logic [pkt_pkg::ADDR_WID-1:0]       start_addr,
    input  logic [pkt_pkg::LEN_WID-1:0]        start_len,
    input  logic [pkt_pkg::META_WID-1:0]       start_meta,
    output logic                               busy,
    // Capture side
    input  logic                               cap_en,
    output logic                               desc_valid,
    output logic [pkt_pkg::LEN_WID-1:0]        desc_len,
    output logic [pkt_pkg::META_WID-1:0]       desc_meta,
    output logic [pkt_pkg::CAP_ADDR_WID-1:0]   desc_addr,
    input  logic [pkt_pkg::CAP_ADDR_WID-1:0]   cap_rd_addr,
    output logic [pkt_pkg::DATA_WID-1:0]       cap_rd_data
);

    // Playback to FIFO link
    logic                 pb_valid;
    logic                 pb_is_hdr;
    pkt_pkg::fifo_word_u  pb_word;
    logic                 pb_credit;

    // FIFO to capture link
    logic                 cap_valid;
    logic                 cap_is_hdr;
    pkt_pkg::fifo_word_u  cap_word;
    logic                 cap_credit;

    //==============================
    // Producer
    //==============================
    packet_playback u_playback (
        .clk          (clk),
        .rst_n        (rst_n),
        .play_wr_en   (play_wr_en),
        .play_wr_addr (play_wr_addr),
        .play_wr_data (play_wr_data),
        .start        (start),
        .start_addr   (start_addr),
        .start_len    (start_len),
        .start_meta   (start_meta),
        .busy         (busy),
        .pb_credit    (pb_credit),
        .pb_valid     (pb_valid),
        .pb_is_hdr    (pb_is_hdr),
        .pb_word      (pb_word)
    );

    // Buffer between the two credit links
    packet_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .pb_valid   (pb_valid),
        .pb_is_hdr  (pb_is_hdr),
        .pb_word    (pb_word),
        .pb_credit  (pb_credit),
        .cap_credit (cap_credit),
        .cap_valid  (cap_valid),
        .cap_is_hdr (cap_is_hdr),
        .cap_word   (cap_word)
    );

    //==============================
    // Consumer
    //==============================
    packet_capture u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .cap_valid   (cap_valid),
        .cap_is_hdr  (cap_is_hdr),
        .cap_word    (cap_word),
        .cap_credit  (cap_credit),
        .cap_en      (cap_en),
        .desc_valid  (desc_valid),
        .desc_len    (desc_len),
        .desc_meta   (desc_meta),
        .desc_addr   (desc_addr),
        .cap_rd_addr (cap_rd_addr),
        .cap_rd_data (cap_rd_data)
    );

endmodule

// ==== tb_packet_checks.svh ====
// Expected packet, pushed at start
typedef struct packed {
    logic [pkt_pkg::LEN_WID-1:0]       len;
    logic [pkt_pkg::META_WID-1:0]      meta;
    logic [pkt_pkg::ADDR_WID-1:0]      addr;
} pkt_rec_t;

// Descriptor as seen on the port
typedef struct packed {
    logic [pkt_pkg::LEN_WID-1:0]       len;
    logic [pkt_pkg::META_WID-1:0]      meta;
    logic [pkt_pkg::CAP_ADDR_WID-1:0]  addr;
} desc_rec_t;

pkt_rec_t                           exp_q[$];
desc_rec_t                          got_q[$];
int unsigned                        desc_seen;
logic                               checking;
// Where the next packet should land
logic [pkt_pkg::CAP_ADDR_WID-1:0]   next_cap_addr;

//==============================
// Reference model
//==============================
function automatic logic [pkt_pkg::DATA_WID-1:0] byte_mask(input int nbytes);
    logic [pkt_pkg::DATA_WID-1:0] m;
    int b;
    m = '0;
    for (b = 0; b < nbytes; b++)
        m = m | (pkt_pkg::DATA_WID'(8'hff) << (8 * b));
    return m;
endfunction

// Bytes of one beat, low byte first, zero past the length
function automatic logic [pkt_pkg::DATA_WID-1:0] expected_beat(
    input logic [pkt_pkg::DATA_WID-1:0] img [pkt_pkg::PLAY_DEPTH],
    input logic [pkt_pkg::ADDR_WID-1:0] base,
    input int                           len,
    input int                           beat
);
    logic [pkt_pkg::ADDR_WID-1:0] a;
    int nbytes;
    // Playback reads wrap around its memory
    a = base + pkt_pkg::ADDR_WID'(beat);
    nbytes = len - beat * 8;
    if (nbytes > 8)
        nbytes = 8;
    return img[a] & byte_mask(nbytes);
endfunction

//==============================
// Compare tasks
//==============================
task automatic compare_desc(
    input logic [pkt_pkg::LEN_WID-1:0]      exp_len,
    input logic [pkt_pkg::LEN_WID-1:0]      got_len,
    input logic [pkt_pkg::META_WID-1:0]     exp_meta,
    input logic [pkt_pkg::META_WID-1:0]     got_meta,
    input logic [pkt_pkg::CAP_ADDR_WID-1:0] exp_addr,
    input logic [pkt_pkg::CAP_ADDR_WID-1:0] got_addr
);
    if (got_len !== exp_len)
        value_fail($sformatf("desc_len %0d, expected %0d", got_len, exp_len));
    else if (got_meta !== exp_meta)
        value_fail($sformatf("desc_meta %0d, expected %0d", got_meta, exp_meta));
    else if (got_addr !== exp_addr)
        value_fail($sformatf("desc_addr %0d, expected %0d", got_addr, exp_addr));
endtask

// Only the first nbytes of the beat count
task automatic compare_word(
    input pkt_pkg::fifo_word_u exp_w,
    input pkt_pkg::fifo_word_u got_w,
    input int                  nbytes,
    input int                  beat
);
    logic [pkt_pkg::DATA_WID-1:0] m;
    m = byte_mask(nbytes);
    if ((got_w.data & m) !== (exp_w.data & m))
        value_fail($sformatf("beat %0d data %h, expected %h",
                             beat, got_w.data & m, exp_w.data & m));
endtask

//==============================
// Descriptor monitor
//==============================
initial
begin
    desc_rec_t d;
    desc_seen = 0;
    forever
    begin
        @(posedge clk);
        #1;
        if (desc_valid === 1'b1)
        begin
            d.len = desc_len;
            d.meta = desc_meta;
            d.addr = desc_addr;
            got_q.push_back(d);
            desc_seen++;
        end
    end
end

// Checker, one descriptor at a time with pipelined read back
initial
begin
    pkt_rec_t rec;
    desc_rec_t got;
    pkt_pkg::fifo_word_u exp_w;
    pkt_pkg::fifo_word_u got_w;
    int beats;
    int nbytes;
    int i;
    checking = 1'b0;
    next_cap_addr = '0;
    forever
    begin
        while (got_q.size() == 0)
        begin
            @(posedge clk);
            #1;
        end
        checking = 1'b1;
        got = got_q.pop_front();
        if (exp_q.size() == 0)
        begin
            fail_run("A descriptor arrived with no packet outstanding");
        end
        else
        begin
            rec = exp_q.pop_front();
            compare_desc(rec.len, got.len, rec.meta, got.meta, next_cap_addr, got.addr);
            beats = (int'(rec.len) + 7) / 8;
            // Address for beat i goes out one cycle before its data
            cap_rd_addr = got.addr;
            for (i = 0; i < beats; i++)
            begin
                @(posedge clk);
                #1;
                got_w.data = cap_rd_data;
                cap_rd_addr = got.addr + pkt_pkg::CAP_ADDR_WID'(i + 1);
                exp_w.data = expected_beat(image, rec.addr, int'(rec.len), i);
                nbytes = int'(rec.len) - i * 8;
                if (nbytes > 8)
                    nbytes = 8;
                compare_word(exp_w, got_w, nbytes, i);
            end
            next_cap_addr = next_cap_addr + pkt_pkg::CAP_ADDR_WID'(beats);
            checking = 1'b0;
        end
    end
end

// ==== tb_packet_loopback.sv ====
module tb_packet_loopback;

    timeunit 1ns;
    timeprecision 1ps;

    logic                                clk;
    logic                                rst_n;
    logic                                play_wr_en;
    logic [pkt_pkg::ADDR_WID-1:0]        play_wr_addr;
    logic [pkt_pkg::DATA_WID-1:0]        play_wr_data;
    logic                                start;
    logic [pkt_pkg::ADDR_WID-1:0]        start_addr;
    logic [pkt_pkg::LEN_WID-1:0]         start_len;
    logic [pkt_pkg::META_WID-1:0]        start_meta;
    logic                                busy;
    logic                                cap_en;
    logic                                desc_valid;
    logic [pkt_pkg::LEN_WID-1:0]         desc_len;
    logic [pkt_pkg::META_WID-1:0]        desc_meta;
    logic [pkt_pkg::CAP_ADDR_WID-1:0]    desc_addr;
    logic [pkt_pkg::CAP_ADDR_WID-1:0]    cap_rd_addr;
    logic [pkt_pkg::DATA_WID-1:0]        cap_rd_data;

    // Copy of the playback memory as loaded
    logic [pkt_pkg::DATA_WID-1:0]        image [pkt_pkg::PLAY_DEPTH];
    int                                  seed;
    int                                  total_beats;
    logic                                sched_ready;
    // Packet list, one entry per start command
    int                                  sched_len[$];
    int                                  sched_meta[$];
    int                                  sched_addr[$];

    //==============================
    // Error exits
    //==============================
    task automatic fail_run(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic value_fail(input string msg);
        fail_run($sformatf("[FAIL] %0d ns: %s", $time, msg));
    endtask

    `include "tb_packet_checks.svh"

    packet_loopback_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .play_wr_en   (play_wr_en),
        .play_wr_addr (play_wr_addr),
        .play_wr_data (play_wr_data),
        .start        (start),
        .start_addr   (start_addr),
        .start_len    (start_len),
        .start_meta   (start_meta),
        .busy         (busy),
        .cap_en       (cap_en),
        .desc_valid   (desc_valid),
        .desc_len     (desc_len),
        .desc_meta    (desc_meta),
        .desc_addr    (desc_addr),
        .cap_rd_addr  (cap_rd_addr),
        .cap_rd_data  (cap_rd_data)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    //==============================
    // Stimulus helpers
    //==============================
    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic schedule_packet(input int len);
        sched_len.push_back(len);
        sched_meta.push_back(rand_range(0, 63));
        sched_addr.push_back(rand_range(0, pkt_pkg::PLAY_DEPTH - 1));
        total_beats += (len + 7) / 8;
    endtask

    task automatic build_schedule();
        int i;
        // Single packet, then the stream of ten
        for (i = 0; i < 11; i++)
            schedule_packet(rand_range(1, 512));
        // Longer than FIFO plus input stage
        schedule_packet(200);
        // Edge lengths
        schedule_packet(1);
        schedule_packet(8);
        schedule_packet(9);
        schedule_packet(512);
        // Enough words to wrap the capture memory
        for (i = 0; i < 8; i++)
            schedule_packet(rand_range(160, 320));
        sched_ready = 1'b1;
    endtask

    // Whole memory, random words with the address mixed in
    task automatic load_image();
        int a;
        logic [pkt_pkg::DATA_WID-1:0] word;
        for (a = 0; a < pkt_pkg::PLAY_DEPTH; a++)
        begin
            word = {$random(seed), $random(seed)} ^ pkt_pkg::DATA_WID'(a);
            image[pkt_pkg::ADDR_WID'(a)] = word;
            play_wr_en = 1'b1;
            play_wr_addr = pkt_pkg::ADDR_WID'(a);
            play_wr_data = word;
            @(posedge clk);
            #1;
        end
        play_wr_en = 1'b0;
    endtask

    task automatic check_idle(input int cycles);
        int n;
        for (n = 0; n < cycles; n++)
        begin
            @(posedge clk);
            #1;
            if (busy !== 1'b0 || desc_valid !== 1'b0)
                value_fail("busy or desc_valid high with no command given");
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after an edge
    task automatic send_packet(input int idx);
        pkt_rec_t rec;
        while (busy)
        begin
            @(posedge clk);
            #1;
        end
        rec.len = pkt_pkg::LEN_WID'(sched_len[idx]);
        rec.meta = pkt_pkg::META_WID'(sched_meta[idx]);
        rec.addr = pkt_pkg::ADDR_WID'(sched_addr[idx]);
        start = 1'b1;
        start_len = rec.len;
        start_meta = rec.meta;
        start_addr = rec.addr;
        exp_q.push_back(rec);
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || got_q.size() != 0 || checking)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    //==============================
    // Watchdog
    //==============================
    initial
    begin
        wait (sched_ready);
        #(4 * (total_beats * 4 + 2000));
        fail_run("Timeout: the run hung and did not finish in its time budget");
    end

    //==============================
    // Test sequence
    //==============================
    initial
    begin
        int i;
        int unsigned seen;
        seed = 87;
        total_beats = 0;
        sched_ready = 1'b0;
        clk = 1'b0;
        rst_n = 1'b0;
        play_wr_en = 1'b0;
        play_wr_addr = '0;
        play_wr_data = '0;
        start = 1'b0;
        start_addr = '0;
        start_len = '0;
        start_meta = '0;
        cap_en = 1'b1;
        cap_rd_addr = '0;
        build_schedule();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Quiet after reset
        check_idle(10);
        load_image();

        // One packet
        send_packet(0);
        wait_drained();

        // Back-to-back stream
        for (i = 1; i <= 10; i++)
            send_packet(i);
        wait_drained();

        // Capture held off, playback must stall
        cap_en = 1'b0;
        seen = desc_seen;
        send_packet(11);
        repeat (100) @(posedge clk);
        #1;
        if (busy !== 1'b1 || desc_seen != seen)
            value_fail("playback did not stall while capture was disabled");
        cap_en = 1'b1;
        wait_drained();

        // Edge lengths
        for (i = 12; i <= 15; i++)
            send_packet(i);
        wait_drained();

        // Capture memory wraparound
        for (i = 16; i <= 23; i++)
            send_packet(i);
        wait_drained();

        if (desc_seen == 24 && exp_q.size() == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            fail_run("Run ended with a wrong number of descriptors");
        end
    end

endmodule

// ==== all.f ====
+incdir+.
pkt_pkg.sv
packet_playback.sv
packet_fifo.sv
packet_capture.sv
packet_loopback_top.sv
tb_packet_loopback.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the packet loopback testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_packet_loopback -Mdir obj_dir -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_packet_loopback
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished"
exit 0
